//--- src/isa_pkg.sv
// ISA definitions for the integer ALU: data width, opcodes and their semantics
`default_nettype none

package isa_pkg;

    localparam int xlen = 32;                 // Data word width

    typedef logic [xlen-1:0] data_t;          // One register value
    typedef logic signed [11:0] imm_t;        // Signed immediate for addi

    // ALU opcodes
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_addi                              // Operand b is the immediate
    } alu_op_t;

    // Sign extend the 12-bit immediate to a full word
    function automatic data_t sext_imm(imm_t imm);
        return {{(xlen-12){imm[11]}}, imm};
    endfunction

    // Result of one ALU operation
    function automatic data_t alu_eval(alu_op_t op, data_t a, data_t b);
        case (op)
            alu_add, alu_addi: return a + b;
            alu_sub:           return a - b;
            alu_and:           return a & b;
            alu_or:            return a | b;
            alu_xor:           return a ^ b;
            default:           return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/core_pkg.sv
// Machine sizes, register tags and the packets moved around the back end
`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int phys_reg_sz = 32;                  // Physical registers
    localparam int tag_w       = $clog2(phys_reg_sz);

    // Defaults for the top level parameters
    localparam int rs_sz      = 8;                    // Reservation station entries
    localparam int num_fu_alu = 3;                    // ALU lanes
    localparam int cdb_width  = 2;                    // CDB ports

    typedef logic [tag_w-1:0] phys_tag_t;

    ////////////////////////////////////////
    // Packets
    ////////////////////////////////////////

    // Renamed operation as it enters the reservation station
    typedef struct packed {
        isa_pkg::alu_op_t op;
        phys_tag_t        src1;
        phys_tag_t        src2;
        phys_tag_t        dest;
        isa_pkg::imm_t    imm;                        // Only read by addi
    } dispatch_packet_t;

    // One common data bus port
    typedef struct packed {
        logic           valid;
        phys_tag_t      tag;
        isa_pkg::data_t value;
    } cdb_packet_t;

endpackage

`default_nettype wire

//--- src/fu_ifs.sv
// Issue and result interfaces between the reservation station, ALU lanes and arbiter
`timescale 1ns/1ns
`default_nettype none

// Reservation station to one ALU lane
interface alu_issue_if;
    import isa_pkg::*;
    import core_pkg::*;

    logic      valid;               // Operation offered this cycle
    alu_op_t   op;
    phys_tag_t dest;
    data_t     a;
    data_t     b;                   // Already the immediate for addi
    logic      free;                // Lane can take an operation now

    modport rs   (output valid, op, dest, a, b, input free);
    modport lane (input valid, op, dest, a, b, output free);
endinterface

// One ALU lane to the CDB arbiter
interface fu_result_if;
    import isa_pkg::*;
    import core_pkg::*;

    logic      valid;               // Result waiting for a CDB port
    phys_tag_t tag;
    data_t     value;
    logic      grant;               // Result goes out this cycle

    modport lane (output valid, tag, value, input grant);
    modport arb  (input valid, tag, value, output grant);
endinterface

`default_nettype wire

//--- src/alu_lane.sv
// One ALU lane: captures an issued operation and holds its result until the CDB takes it
`timescale 1ns/1ns
`default_nettype none

module alu_lane (
    input  logic       clock,
    input  logic       rst,
    alu_issue_if.lane  issue,
    fu_result_if.lane  result
);
    import isa_pkg::*;
    import core_pkg::*;

    logic      busy;                 // Holding a result
    alu_op_t   op_q;
    phys_tag_t tag_q;
    data_t     a_q;
    data_t     b_q;
    logic      capture;

    // Free when empty or draining this cycle
    assign issue.free = !busy || result.grant;
    assign capture    = issue.valid && issue.free;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (capture) begin
            busy <= 1'b1;            // Back to back ops keep it busy
        end else if (result.grant) begin
            busy <= 1'b0;
        end
    end

    // Operands and tag, no reset needed
    always_ff @(posedge clock) begin
        if (capture) begin
            op_q  <= issue.op;
            tag_q <= issue.dest;
            a_q   <= issue.a;
            b_q   <= issue.b;
        end
    end

    assign result.valid = busy;
    assign result.tag   = tag_q;
    assign result.value = alu_eval(op_q, a_q, b_q);   // Stable while held

endmodule

`default_nettype wire

//--- src/cdb_arbiter.sv
// Round-robin arbiter that moves lane results onto the CDB ports
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter #(
    parameter int NUM_FU_ALU = core_pkg::num_fu_alu,
    parameter int CDB_WIDTH  = core_pkg::cdb_width
) (
    input  logic                                   clock,
    input  logic                                   rst,
    output core_pkg::cdb_packet_t [CDB_WIDTH-1:0]  cdb,
    fu_result_if.arb                               lanes [NUM_FU_ALU]
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int PTR_W = (NUM_FU_ALU > 1) ? $clog2(NUM_FU_ALU) : 1;

    logic [NUM_FU_ALU-1:0] req;
    logic [NUM_FU_ALU-1:0] gnt;
    phys_tag_t             tags [NUM_FU_ALU];
    data_t                 vals [NUM_FU_ALU];
    logic [PTR_W-1:0]      ptr;              // First lane searched
    logic [PTR_W-1:0]      last_gnt;

    for (genvar i = 0; i < NUM_FU_ALU; i++) begin : g_lane
        assign req[i]         = lanes[i].valid;
        assign tags[i]        = lanes[i].tag;
        assign vals[i]        = lanes[i].value;
        assign lanes[i].grant = gnt[i];
    end

    ////////////////////////////////////////
    // Grant
    ////////////////////////////////////////

    // Walk the lanes from ptr, filling ports in grant order
    always_comb begin
        int idx;
        int n;
        gnt      = '0;
        cdb      = '0;
        last_gnt = ptr;
        n        = 0;
        for (int k = 0; k < NUM_FU_ALU; k++) begin
            idx = (int'(ptr) + k) % NUM_FU_ALU;
            if (req[idx] && n < CDB_WIDTH) begin
                gnt[idx]     = 1'b1;
                cdb[n].valid = 1'b1;
                cdb[n].tag   = tags[idx];
                cdb[n].value = vals[idx];
                last_gnt     = PTR_W'(idx);
                n++;
            end
        end
    end

    // Pointer moves just past the last lane granted
    always_ff @(posedge clock) begin
        if (rst) begin
            ptr <= '0;
        end else if (|gnt) begin
            ptr <= (last_gnt == PTR_W'(NUM_FU_ALU-1)) ? '0 : last_gnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/phys_regfile.sv
// Physical register file with per-register ready bits, written from the CDB
`timescale 1ns/1ns
`default_nettype none

module phys_regfile #(
    parameter int NUM_FU_ALU = core_pkg::num_fu_alu,
    parameter int CDB_WIDTH  = core_pkg::cdb_width
) (
    input  logic                                    clock,
    input  logic                                    rst,
    input  core_pkg::cdb_packet_t [CDB_WIDTH-1:0]   cdb,
    input  logic                                    alloc_valid,  // Accepted dispatch
    input  core_pkg::phys_tag_t                     alloc_tag,
    input  core_pkg::phys_tag_t [2*NUM_FU_ALU-1:0]  rd_tag,
    output isa_pkg::data_t [2*NUM_FU_ALU-1:0]       rd_data,
    output logic [core_pkg::phys_reg_sz-1:0]        src_ready
);
    import isa_pkg::*;
    import core_pkg::*;

    data_t regs [phys_reg_sz];

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int r = 0; r < phys_reg_sz; r++) begin
                regs[r] <= '0;                        // Registers start at zero
            end
            src_ready <= '1;                          // and all ready
        end else begin
            // New destination waits for its result
            if (alloc_valid) src_ready[alloc_tag] <= 1'b0;
            for (int p = 0; p < CDB_WIDTH; p++) begin
                if (cdb[p].valid) begin
                    regs[cdb[p].tag]      <= cdb[p].value;
                    src_ready[cdb[p].tag] <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // Asynchronous reads, CDB writes show up next cycle
    always_comb begin
        for (int k = 0; k < 2*NUM_FU_ALU; k++) begin
            rd_data[k] = regs[rd_tag[k]];
        end
    end

endmodule

`default_nettype wire

//--- src/reservation_station.sv
// Reservation station: holds renamed ALU operations, wakes them on the CDB, issues to free lanes
`timescale 1ns/1ns
`default_nettype none

module reservation_station #(
    parameter int RS_SZ      = core_pkg::rs_sz,
    parameter int NUM_FU_ALU = core_pkg::num_fu_alu,
    parameter int CDB_WIDTH  = core_pkg::cdb_width
) (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    dispatch_valid,
    input  core_pkg::dispatch_packet_t              dispatch,
    input  core_pkg::cdb_packet_t [CDB_WIDTH-1:0]   cdb,
    input  logic [core_pkg::phys_reg_sz-1:0]        src_ready,   // From the register file
    input  isa_pkg::data_t [2*NUM_FU_ALU-1:0]       rd_data,
    output logic                                    rs_full,
    output core_pkg::phys_tag_t [2*NUM_FU_ALU-1:0]  rd_tag,      // Two read ports per lane
    alu_issue_if.rs                                 issue [NUM_FU_ALU]
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int IDX_W = (RS_SZ > 1) ? $clog2(RS_SZ) : 1;

    // Entry state
    logic             [RS_SZ-1:0] valid;
    logic             [RS_SZ-1:0] rdy1;
    logic             [RS_SZ-1:0] rdy2;
    dispatch_packet_t             ent [RS_SZ];          // Payload, no reset

    logic [RS_SZ-1:0]           ready_ent;              // Both sources ready
    logic [RS_SZ-1:0]           taken;                  // Issued this cycle
    logic [NUM_FU_ALU-1:0]      lane_free;
    logic [NUM_FU_ALU-1:0]      sel_valid;
    logic [IDX_W-1:0]           sel_idx [NUM_FU_ALU];
    dispatch_packet_t           sel_pkt [NUM_FU_ALU];
    logic [IDX_W-1:0]           free_idx;
    logic                       accept;
    logic                       src1_now;
    logic                       src2_now;

    assign rs_full   = &valid;                          // Every entry occupied
    assign accept    = dispatch_valid && !rs_full;      // Strobe while full is dropped
    assign ready_ent = valid & rdy1 & rdy2;

    ////////////////////////////////////////
    // Dispatch
    ////////////////////////////////////////

    // Lowest empty entry
    always_comb begin
        logic found;
        found    = 1'b0;
        free_idx = '0;
        for (int e = 0; e < RS_SZ; e++) begin
            if (!found && !valid[e]) begin
                found    = 1'b1;
                free_idx = IDX_W'(e);
            end
        end
    end

    // Source readiness with same cycle CDB bypass
    always_comb begin
        src1_now = src_ready[dispatch.src1];
        src2_now = src_ready[dispatch.src2] || (dispatch.op == alu_addi); // addi has no src2
        for (int p = 0; p < CDB_WIDTH; p++) begin
            if (cdb[p].valid) begin
                if (cdb[p].tag == dispatch.src1) src1_now = 1'b1;
                if (cdb[p].tag == dispatch.src2) src2_now = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Select
    ////////////////////////////////////////

    // Each free lane in turn takes the lowest ready entry still untaken
    always_comb begin
        logic found;
        taken     = '0;
        sel_valid = '0;
        for (int l = 0; l < NUM_FU_ALU; l++) begin
            found      = 1'b0;
            sel_idx[l] = '0;
            if (lane_free[l]) begin
                for (int e = 0; e < RS_SZ; e++) begin
                    if (!found && ready_ent[e] && !taken[e]) begin
                        found      = 1'b1;
                        sel_idx[l] = IDX_W'(e);
                    end
                end
            end
            if (found) taken[sel_idx[l]] = 1'b1;
            sel_valid[l] = found;
            sel_pkt[l]   = ent[sel_idx[l]];
        end
    end

    // Operand read and lane drive
    for (genvar i = 0; i < NUM_FU_ALU; i++) begin : g_lane
        assign lane_free[i]    = issue[i].free;
        assign rd_tag[2*i]     = sel_pkt[i].src1;
        assign rd_tag[2*i+1]   = sel_pkt[i].src2;
        assign issue[i].valid  = sel_valid[i];
        assign issue[i].op     = sel_pkt[i].op;
        assign issue[i].dest   = sel_pkt[i].dest;
        assign issue[i].a      = rd_data[2*i];
        assign issue[i].b      = (sel_pkt[i].op == alu_addi) ? sext_imm(sel_pkt[i].imm)
                                                             : rd_data[2*i+1];
    end

    ////////////////////////////////////////
    // State update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            valid <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
        end else begin
            for (int e = 0; e < RS_SZ; e++) begin
                if (taken[e]) valid[e] <= 1'b0;          // Issued entries leave
                for (int p = 0; p < CDB_WIDTH; p++) begin
                    if (cdb[p].valid && cdb[p].tag == ent[e].src1) rdy1[e] <= 1'b1; // Wakeup
                    if (cdb[p].valid && cdb[p].tag == ent[e].src2) rdy2[e] <= 1'b1;
                end
            end
            if (accept) begin
                valid[free_idx] <= 1'b1;
                rdy1[free_idx]  <= src1_now;
                rdy2[free_idx]  <= src2_now;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) ent[free_idx] <= dispatch;
    end

endmodule

`default_nettype wire

//--- src/ooo_issue_core.sv
// Back end top: reservation station, register file, ALU lanes and CDB arbiter
`timescale 1ns/1ns
`default_nettype none

module ooo_issue_core #(
    parameter int RS_SZ      = core_pkg::rs_sz,
    parameter int NUM_FU_ALU = core_pkg::num_fu_alu,
    parameter int CDB_WIDTH  = core_pkg::cdb_width
) (
    input  logic                                  clock,
    input  logic                                  rst,
    // Dispatch
    input  logic                                  dispatch_valid,
    input  isa_pkg::alu_op_t                      dispatch_op,
    input  core_pkg::phys_tag_t                   dispatch_src1,
    input  core_pkg::phys_tag_t                   dispatch_src2,
    input  core_pkg::phys_tag_t                   dispatch_dest,
    input  isa_pkg::imm_t                         dispatch_imm,
    output logic                                  rs_full,
    // Common data bus
    output logic [CDB_WIDTH-1:0]                  cdb_valid,
    output core_pkg::phys_tag_t [CDB_WIDTH-1:0]   cdb_tag,
    output isa_pkg::data_t [CDB_WIDTH-1:0]        cdb_value
);
    import isa_pkg::*;
    import core_pkg::*;

    dispatch_packet_t                   dispatch_pkt;
    cdb_packet_t [CDB_WIDTH-1:0]        cdb;
    logic [phys_reg_sz-1:0]             src_ready;
    phys_tag_t [2*NUM_FU_ALU-1:0]       rd_tag;
    data_t [2*NUM_FU_ALU-1:0]           rd_data;
    logic                               alloc_valid;

    alu_issue_if issue_ifs  [NUM_FU_ALU] ();
    fu_result_if result_ifs [NUM_FU_ALU] ();

    assign dispatch_pkt = '{op: dispatch_op, src1: dispatch_src1, src2: dispatch_src2,
                            dest: dispatch_dest, imm: dispatch_imm};
    assign alloc_valid  = dispatch_valid && !rs_full;   // Same accept rule as the RS

    ////////////////////////////////////////
    // Issue side
    ////////////////////////////////////////

    reservation_station #(
        .RS_SZ      (RS_SZ),
        .NUM_FU_ALU (NUM_FU_ALU),
        .CDB_WIDTH  (CDB_WIDTH)
    ) rs_inst (
        .clock          (clock),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch_pkt),
        .cdb            (cdb),
        .src_ready      (src_ready),
        .rd_data        (rd_data),
        .rs_full        (rs_full),
        .rd_tag         (rd_tag),
        .issue          (issue_ifs)
    );

    phys_regfile #(
        .NUM_FU_ALU (NUM_FU_ALU),
        .CDB_WIDTH  (CDB_WIDTH)
    ) regfile_inst (
        .clock       (clock),
        .rst         (rst),
        .cdb         (cdb),
        .alloc_valid (alloc_valid),
        .alloc_tag   (dispatch_dest),
        .rd_tag      (rd_tag),
        .rd_data     (rd_data),
        .src_ready   (src_ready)
    );

    ////////////////////////////////////////
    // Execute and complete
    ////////////////////////////////////////

    for (genvar i = 0; i < NUM_FU_ALU; i++) begin : g_alu
        alu_lane alu_inst (
            .clock  (clock),
            .rst    (rst),
            .issue  (issue_ifs[i]),
            .result (result_ifs[i])
        );
    end

    cdb_arbiter #(
        .NUM_FU_ALU (NUM_FU_ALU),
        .CDB_WIDTH  (CDB_WIDTH)
    ) arb_inst (
        .clock (clock),
        .rst   (rst),
        .cdb   (cdb),
        .lanes (result_ifs)
    );

    // CDB out to the pins
    for (genvar p = 0; p < CDB_WIDTH; p++) begin : g_cdb
        assign cdb_valid[p] = cdb[p].valid;
        assign cdb_tag[p]   = cdb[p].tag;
        assign cdb_value[p] = cdb[p].value;
    end

endmodule

`default_nettype wire

//--- testbench/tb_ooo_issue_core.sv
// Testbench for the out-of-order back end with a random dispatch stream and a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_issue_core;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int rs_depth     = rs_sz;
    localparam int alu_lanes    = num_fu_alu;
    localparam int cdb_ports    = cdb_width;
    localparam int seed         = 13830;
    localparam int total_ops    = 30 + 60 + 22 + 4*9;         // Ops over all tests
    localparam int op_bound_cyc = 40;                         // Generous cycles per op
    localparam int drain_cyc    = (rs_depth + alu_lanes) * op_bound_cyc;  // Bound on one drain
    localparam int watchdog_ns  = (total_ops * op_bound_cyc + 300) * 10;

    logic                          clock;
    logic                          rst;
    logic                          dispatch_valid;
    alu_op_t                       dispatch_op;
    phys_tag_t                     dispatch_src1;
    phys_tag_t                     dispatch_src2;
    phys_tag_t                     dispatch_dest;
    imm_t                          dispatch_imm;
    logic                          rs_full;
    logic [cdb_ports-1:0]          cdb_valid;
    phys_tag_t [cdb_ports-1:0]     cdb_tag;
    data_t [cdb_ports-1:0]         cdb_value;

    // Reference model indexed by destination tag
    data_t     model_reg [phys_reg_sz];                       // Values in dispatch order
    data_t     exp_val   [phys_reg_sz];
    bit        in_flight [phys_reg_sz];
    int        readers   [phys_reg_sz];                       // In-flight ops reading the tag
    phys_tag_t op_s1     [phys_reg_sz];
    phys_tag_t op_s2     [phys_reg_sz];
    bit        op_use2   [phys_reg_sz];                       // addi ignores src2

    int        inflight_cnt;
    int        sent;                                          // Accepted in this phase
    int        gen_idx;
    int        chain_len;
    int        dispatched;
    int        completed;
    int        checks;
    int        errors;
    int        max_bc;
    int        err_mark;
    bit        full_seen;
    bit        full_q;                                        // rs_full seen at last negedge
    bit        pending;
    phys_tag_t chain_tag;
    alu_op_t   p_op;
    phys_tag_t p_src1;
    phys_tag_t p_src2;
    phys_tag_t p_dest;
    imm_t      p_imm;

    ooo_issue_core #(
        .RS_SZ      (rs_depth),
        .NUM_FU_ALU (alu_lanes),
        .CDB_WIDTH  (cdb_ports)
    ) ooo_issue_core_inst (
        .clock          (clock),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_src1  (dispatch_src1),
        .dispatch_src2  (dispatch_src2),
        .dispatch_dest  (dispatch_dest),
        .dispatch_imm   (dispatch_imm),
        .rs_full        (rs_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;                            // 10 ns period
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
        end
    endtask

    // Opcode semantics with b already the immediate for addi
    function automatic data_t model_alu(alu_op_t op, data_t a, data_t b);
        case (op)
            alu_add, alu_addi: return a + b;
            alu_sub:           return a + ~b + 32'd1;         // Two's complement negate
            alu_and:           return a & b;
            alu_or:            return a | b;
            alu_xor:           return (a | b) & ~(a & b);
            default:           return '0;
        endcase
    endfunction

    // Random tag with no producer in flight
    function automatic phys_tag_t pick_ready();
        int start;
        start = $urandom % phys_reg_sz;
        for (int k = 0; k < phys_reg_sz; k++) begin
            if (!in_flight[(start + k) % phys_reg_sz])
                return phys_tag_t'((start + k) % phys_reg_sz);
        end
        return phys_tag_t'(start);
    endfunction

    // Destination that nothing in flight writes or reads
    task automatic pick_dest(input phys_tag_t s1, input phys_tag_t s2, output bit ok,
                             output phys_tag_t d);
        int start;
        int t;
        start = $urandom % phys_reg_sz;
        ok    = 1'b0;
        d     = '0;
        for (int k = 0; k < phys_reg_sz; k++) begin
            t = (start + k) % phys_reg_sz;
            if (!ok && !in_flight[t] && readers[t] == 0 && t != int'(s1) && t != int'(s2)) begin
                ok = 1'b1;
                d  = phys_tag_t'(t);
            end
        end
    endtask

    // Mode 0 independent, 1 random sources, 2 slow chain with waiters on its tail
    task automatic make_op(input int mode, output bit ok);
        phys_tag_t s1;
        phys_tag_t s2;
        phys_tag_t d;
        case (mode)
            0: begin
                s1 = pick_ready();
                s2 = pick_ready();
            end
            1: begin
                s1 = phys_tag_t'($urandom % phys_reg_sz);
                s2 = phys_tag_t'($urandom % phys_reg_sz);
            end
            default: begin
                s1 = (gen_idx == 0) ? pick_ready() : chain_tag;
                s2 = pick_ready();
            end
        endcase
        pick_dest(s1, s2, ok, d);
        if (ok) begin
            p_op   = alu_op_t'(3'($urandom % 6));
            p_imm  = imm_t'(12'($urandom));
            p_src1 = s1;
            p_src2 = s2;
            p_dest = d;
            if (mode == 2 && gen_idx < chain_len) chain_tag = d;   // Chain grows until full length
            gen_idx++;
        end
    endtask

    // Record an accepted dispatch against the values in dispatch order
    task automatic accept_op();
        data_t a;
        data_t b;
        data_t res;
        a   = model_reg[dispatch_src1];
        b   = (dispatch_op == alu_addi) ? data_t'(int'(dispatch_imm))
                                        : model_reg[dispatch_src2];
        res = model_alu(dispatch_op, a, b);
        model_reg[dispatch_dest] = res;
        exp_val[dispatch_dest]   = res;
        in_flight[dispatch_dest] = 1'b1;
        op_s1[dispatch_dest]     = dispatch_src1;
        op_s2[dispatch_dest]     = dispatch_src2;
        op_use2[dispatch_dest]   = (dispatch_op != alu_addi);
        readers[dispatch_src1]++;
        if (dispatch_op != alu_addi) readers[dispatch_src2]++;
        inflight_cnt++;
        dispatched++;
        sent++;
        pending = 1'b0;
    endtask

    task automatic retire_tag(input phys_tag_t t);
        in_flight[t] = 1'b0;
        readers[op_s1[t]]--;
        if (op_use2[t]) readers[op_s2[t]]--;
        inflight_cnt--;
        completed++;
    endtask

    ////////////////////////////////////////
    // Monitor
    ////////////////////////////////////////

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        int        n_bc;
        int        blocked;
        phys_tag_t t;
        if (!rst) begin
            blocked = 0;                                      // Entries that must still sit in the RS
            for (int i = 0; i < phys_reg_sz; i++) begin
                if (in_flight[i] && (in_flight[op_s1[i]] || (op_use2[i] && in_flight[op_s2[i]])))
                    blocked++;
            end
            if (blocked == rs_depth)
                check_equal(32'(rs_full), 32'd1, "rs_full with every entry blocked");
            if (inflight_cnt < rs_depth)
                check_equal(32'(rs_full), 32'd0, "rs_full with free entries");
            if (rs_full) full_seen = 1'b1;
            n_bc = 0;
            for (int p = 0; p < cdb_ports; p++) begin
                if (cdb_valid[p]) begin
                    n_bc++;
                    t = cdb_tag[p];
                    if (!in_flight[t]) begin
                        errors++;
                        $display("Error at %0t: tag %0d broadcast with no operation in flight",
                                 $time, t);
                    end else begin
                        check_equal(cdb_value[p], exp_val[t], $sformatf("CDB value of tag %0d", t));
                        retire_tag(t);
                    end
                end
            end
            if (n_bc > max_bc) max_bc = n_bc;
            full_q = rs_full;
            if (dispatch_valid && !rs_full) accept_op();      // Written at the coming edge
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic dispatch_ops(input int n, input int mode, input int clen, input bit gaps);
        sent      = 0;
        gen_idx   = 0;
        chain_len = clen;
        pending   = 1'b0;
        do begin
            @(posedge clock);
            if (sent < n) begin
                if (!pending) make_op(mode, pending);
                if (pending && !full_q && !(gaps && $urandom % 4 == 0)) begin
                    dispatch_valid <= 1'b1;
                    dispatch_op    <= p_op;
                    dispatch_src1  <= p_src1;
                    dispatch_src2  <= p_src2;
                    dispatch_dest  <= p_dest;
                    dispatch_imm   <= p_imm;
                end else begin
                    dispatch_valid <= 1'b0;                   // Gap, stall or no free tag
                end
            end else begin
                dispatch_valid <= 1'b0;
            end
        end while (sent < n);
    endtask

    // Wait for the model to empty within drain_cyc cycles
    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (inflight_cnt != 0 && waited < drain_cyc) begin
            @(posedge clock);
            waited++;
        end
        check_equal(inflight_cnt, 0, "operations left in flight");
        repeat (3) @(posedge clock);
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d, %s: %s", num, name, (errors == err_mark) ? "ok" : "mismatches found");
        err_mark = errors;
    endtask

    initial begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = alu_add;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_dest  = '0;
        dispatch_imm   = '0;
        for (int i = 0; i < phys_reg_sz; i++) begin
            model_reg[i] = '0;                                // Registers come out of reset at zero
            exp_val[i]   = '0;
            op_s1[i]     = '0;
            op_s2[i]     = '0;
        end
        void'($urandom(seed));
        repeat (4) @(posedge clock);
        rst <= 1'b0;

        repeat (20) @(posedge clock);                         // Idle with no dispatch
        report_test(1, "idle after reset");
        dispatch_ops(30, 0, 0, 1'b1);
        drain_pipeline();
        report_test(2, "independent operations");
        dispatch_ops(60, 1, 0, 1'b1);
        drain_pipeline();
        report_test(3, "dependent chains");
        full_seen = 1'b0;
        dispatch_ops(22, 2, 8, 1'b0);
        drain_pipeline();
        check_equal(32'(full_seen), 32'd1, "rs_full raised during the burst");
        report_test(4, "burst behind a slow chain");
        max_bc = 0;
        repeat (4) dispatch_ops(9, 2, 3, 1'b0);
        drain_pipeline();
        check_equal(max_bc, cdb_ports, "peak broadcasts per cycle under contention");
        report_test(5, $sformatf("CDB contention, peak %0d broadcasts", max_bc));

        $display("Summary: 5 tests, %0d ops dispatched, %0d completed, %0d checks, %0d errors",
                 dispatched, completed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/isa_pkg.sv
src/core_pkg.sv
src/fu_ifs.sv
src/alu_lane.sv
src/cdb_arbiter.sv
src/phys_regfile.sv
src/reservation_station.sv
src/ooo_issue_core.sv
testbench/tb_ooo_issue_core.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_ooo_issue_core -o tb_sim \
    && ./obj_dir/tb_sim > sim.log \
    || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "FAIL: no verdict in log"; exit 1; }
echo "PASS"
exit 0
